// ==== flist.f ====
zx_pkg.sv
ula_io.sv
paging_regs.sv
mem_map.sv
input_ports.sv
zx_core_top.sv
tb_zx_core_sva.sv
tb_zx_core.sv

// ==== Makefile ====
LOG = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, and look for the pass message"
	@echo "  clean  remove build output and log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -f flist.f --top-module tb_zx_core -o sim_zx
	./obj_dir/sim_zx | tee $(LOG)
	grep -q "TEST OK" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// ==== tb_zx_core.sv ====
//======================================================================
// Directed testbench for the memory and I/O core
//   clock, reset and bus master tasks
//   ULA port, 128K, +3, Pentagon 1024, 48K and input port tests
//======================================================================
`timescale 1ns/10ps
`default_nettype none

module tb_zx_core;

	logic        clk_sys = 1'b0;
	logic        reset = 1'b1;
	logic  [2:0] machine = 3'd0;
	logic [15:0] addr = 16'd0;
	logic  [7:0] dout = 8'd0;
	logic        mreq = 1'b0;
	logic        iorq = 1'b0;
	logic        rd = 1'b0;
	logic        wr = 1'b0;
	logic        m1 = 1'b0;
	logic  [7:0] ram_rdata = 8'h5A;
	logic [39:0] key_matrix = 40'd0;
	logic  [5:0] joy0 = 6'd0;
	logic  [5:0] joy1 = 6'd0;
	logic  [2:0] jsel = 3'd0;
	wire   [7:0] din;
	wire  [24:0] ram_addr;
	wire         ram_rd;
	wire         ram_we;
	wire   [7:0] ram_wdata;
	wire   [2:0] border_color;
	wire         ear_out;
	wire         mic_out;

	int          seed = 32'h50b50ab3;
	logic        settled;     // Bus seen idle at the last rising edge
	logic [24:0] cap_addr;
	logic  [7:0] cap_din;
	logic  [7:0] cap_wdata;
	logic        cap_rd;
	logic        cap_we;

	zx_core_top zx_core_top_inst (.*);

	always #20 clk_sys = ~clk_sys;

	always @(posedge clk_sys) begin
		settled <= ~(mreq | iorq);
	end

	task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
		assert (got === exp) else begin
			$display("[ERROR] %0t ns %s = %h, expected %h", $time, name, got, exp);
			$display("TEST FAILED");
			$fatal(1);
		end
	endtask

	task automatic fail_timeout(input string what);
		$display("Timeout while waiting for %s", what);
		$display("TEST FAILED");
		$fatal(1);
	endtask

	task automatic apply_reset(input logic [2:0] mode);
		@(negedge clk_sys);
		machine = mode;
		reset = 1'b1;
		repeat (5) @(negedge clk_sys);
		reset = 1'b0;
	endtask

	// Three cycles on the bus, then release and wait for idle
	task automatic bus_cycle(input logic [15:0] a, input logic [7:0] d, input logic io,
			input logic write);
		int n;
		n = 0;
		addr = a;
		dout = d;
		iorq = io;
		mreq = ~io;
		rd = ~write;
		wr = write;
		repeat (2) @(negedge clk_sys);
		cap_addr = ram_addr;
		cap_din = din;
		cap_rd = ram_rd;
		cap_we = ram_we;
		cap_wdata = ram_wdata;
		@(negedge clk_sys);
		{mreq, iorq, rd, wr} = 4'b0000;
		@(negedge clk_sys);
		while (!settled) begin
			if (n >= 8) fail_timeout("bus to settle");
			@(negedge clk_sys);
			n++;
		end
	endtask

	task automatic io_write(input logic [15:0] a, input logic [7:0] d);
		bus_cycle(a, d, 1'b1, 1'b1);
	endtask

	task automatic io_read(input logic [15:0] a, input logic [7:0] exp);
		bus_cycle(a, 8'h00, 1'b1, 1'b0);
		check_val("din", cap_din, exp);
	endtask

	task automatic mem_access(input logic [15:0] a, input logic write, input logic [24:0] exp,
			input logic exp_we);
		bus_cycle(a, 8'hC3, 1'b0, write);
		check_val("ram_addr", cap_addr, exp);
		check_val("ram_we", cap_we, exp_we);
		check_val("ram_rd", cap_rd, !write);
		if (write) begin
			check_val("ram_wdata", cap_wdata, 8'hC3);
		end else begin
			check_val("din", cap_din, ram_rdata);
		end
	endtask

	function automatic logic [24:0] bank_addr(input logic [5:0] bank, input logic [15:0] a);
		return {5'd0, bank, a[13:0]};
	endfunction

	function automatic logic [24:0] rom_addr(input logic [3:0] pg, input logic [15:0] a);
		return {4'd0, 3'b101, pg, a[13:0]};
	endfunction

	// Each low high-byte bit selects a row, pressed keys read 0
	function automatic logic [7:0] key_byte(input logic [7:0] hi, input logic [39:0] km);
		logic [4:0] k;
		k = 5'b11111;
		for (int r = 0; r < 8; r++) begin
			if (!hi[r]) k = k & ~km[r*5 +: 5];
		end
		return {3'b111, k};
	endfunction

	//======================================================================
	// Tests
	//======================================================================
	task automatic test_ula;
		io_write(16'h00FE, 8'h1D);
		check_val("border_color", border_color, 3'd5);
		check_val("ear_out", ear_out, 1'b1);
		check_val("mic_out", mic_out, 1'b1);
		io_write(16'h00FF, 8'h02);  // Odd port
		check_val("border_color", border_color, 3'd5);
		io_write(16'h00FE, 8'h0A);
		check_val("border_color", border_color, 3'd2);
		check_val("ear_out", ear_out, 1'b0);
		check_val("mic_out", mic_out, 1'b1);
	endtask

	task automatic test_128k;
		apply_reset(3'd0);
		check_val("border_color", border_color, 3'd0);
		check_val("mic_out", mic_out, 1'b0);
		io_write(16'h7FFD, 8'h03);
		mem_access(16'hC123, 1'b0, bank_addr(6'd3, 16'hC123), 1'b0);
		mem_access(16'h4010, 1'b0, bank_addr(6'd5, 16'h4010), 1'b0);
		mem_access(16'h8020, 1'b1, bank_addr(6'd2, 16'h8020), 1'b1);
		mem_access(16'h0010, 1'b0, rom_addr(4'b0110, 16'h0010), 1'b0);
		io_write(16'h7FFD, 8'h10);
		mem_access(16'h0010, 1'b0, rom_addr(4'b0111, 16'h0010), 1'b0);
		io_write(16'h7FFD, 8'h26);  // Bank 6 and lock
		io_write(16'h7FFD, 8'h01);
		mem_access(16'hC000, 1'b0, bank_addr(6'd6, 16'hC000), 1'b0);
		apply_reset(3'd0);
		io_write(16'h7FFD, 8'h01);
		mem_access(16'hC000, 1'b0, bank_addr(6'd1, 16'hC000), 1'b0);
	endtask

	task automatic test_plus3;
		apply_reset(3'd4);
		io_write(16'h1FFD, 8'h01);  // Special, banks 0-3
		mem_access(16'h0100, 1'b1, bank_addr(6'd0, 16'h0100), 1'b1);
		mem_access(16'h4100, 1'b0, bank_addr(6'd1, 16'h4100), 1'b0);
		mem_access(16'h8100, 1'b0, bank_addr(6'd2, 16'h8100), 1'b0);
		mem_access(16'hC100, 1'b0, bank_addr(6'd3, 16'hC100), 1'b0);
		io_write(16'h1FFD, 8'h07);  // Banks 4, 7, 6, 3
		mem_access(16'h0200, 1'b0, bank_addr(6'd4, 16'h0200), 1'b0);
		mem_access(16'h4200, 1'b0, bank_addr(6'd7, 16'h4200), 1'b0);
		mem_access(16'h8200, 1'b0, bank_addr(6'd6, 16'h8200), 1'b0);
		mem_access(16'hC200, 1'b0, bank_addr(6'd3, 16'hC200), 1'b0);
		io_write(16'h1FFD, 8'h04);
		io_write(16'h7FFD, 8'h10);
		mem_access(16'h0000, 1'b0, rom_addr(4'b1011, 16'h0000), 1'b0);
		io_write(16'h3FFD, 8'h03);  // A14 low, ignored on +3
		mem_access(16'h0000, 1'b1, rom_addr(4'b1011, 16'h0000), 1'b0);
		mem_access(16'hC000, 1'b1, bank_addr(6'd0, 16'hC000), 1'b1);
	endtask

	task automatic test_p1024;
		apply_reset(3'd1);
		io_write(16'h7FFD, 8'hE3);
		mem_access(16'hC000, 1'b0, bank_addr(6'h3B, 16'hC000), 1'b0);
		io_write(16'h7FFD, 8'hC1);  // Extra bits 5,7,6 give 011
		mem_access(16'hC000, 1'b0, bank_addr(6'h19, 16'hC000), 1'b0);
		io_write(16'hEFF7, 8'h04);
		io_write(16'h7FFD, 8'hE5);  // Extended bank frozen
		mem_access(16'hC000, 1'b0, bank_addr(6'h1D, 16'hC000), 1'b0);
		io_write(16'h7FFD, 8'h02);  // Bit 5 now locks
		mem_access(16'hC000, 1'b0, bank_addr(6'h1D, 16'hC000), 1'b0);
	endtask

	task automatic test_48k;
		apply_reset(3'd3);
		io_write(16'h7FFD, 8'h07);
		mem_access(16'hC000, 1'b0, bank_addr(6'd0, 16'hC000), 1'b0);
		mem_access(16'h0040, 1'b1, rom_addr(4'b1111, 16'h0040), 1'b0);
	endtask

	task automatic test_inputs;
		logic [7:0] hi;
		apply_reset(3'd0);
		for (int i = 0; i < 8; i++) begin
			key_matrix = {$random(seed), $random(seed)};
			hi = (i == 0) ? 8'h00 : (i == 1) ? 8'hFF : $random(seed);
			io_read({hi, 8'hFE}, key_byte(hi, key_matrix));
		end
		key_matrix = 40'd0;
		joy0 = 6'h05;
		joy1 = 6'h10;
		io_read(16'h001F, 8'h15);   // Kempston
		jsel = 3'd1;
		joy0 = 6'h08;
		joy1 = 6'h00;
		io_read(16'hEFFE, 8'hFD);   // Up is key 9
		jsel = 3'd2;
		joy0 = 6'h00;
		joy1 = 6'h10;
		io_read(16'hF7FE, 8'hEF);   // Fire is key 5
		jsel = 3'd3;
		joy0 = 6'h01;
		joy1 = 6'h02;
		io_read(16'hE7FE, 8'hF6);   // Right is key 7, left is key 1
		jsel = 3'd4;
		joy0 = 6'h14;
		joy1 = 6'h00;
		io_read(16'hEFFE, 8'hEE);   // Cursor down and fire
		joy0 = 6'h00;
		joy1 = 6'h02;
		io_read(16'hF7FE, 8'hEF);   // Cursor left
		io_read(16'h001F, 8'hFF);
	endtask

	initial begin
		apply_reset(3'd0);
		test_ula();
		test_128k();
		test_plus3();
		test_p1024();
		test_48k();
		test_inputs();
		if (zx_core_top_inst.tb_zx_core_sva_inst.error_count == 0) begin
			$display("TEST OK");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

	initial begin
		#400000;
		fail_timeout("the end of the test sequence");
	end

endmodule

`default_nettype wire

// ==== tb_zx_core_sva.sv ====
//======================================================================
// Bound assertions for the core
//   read and write strobes exclusive
//   paging registers change only on a write pulse
//   7FFD register frozen while paging is locked
//======================================================================
`timescale 1ns/10ps
`default_nettype none

module tb_zx_core_sva (
	input wire       clk_sys,
	input wire       reset,
	input wire       ram_rd,
	input wire       ram_we,
	input wire       wr_7ffd_cand,
	input wire       wr_1ffd_cand,
	input wire       wr_eff7_cand,
	input wire [7:0] page_7ffd,
	input wire [7:0] page_1ffd,
	input wire [2:0] page_128k,
	input wire       page_lock
);

	logic any_wr;
	int   error_count = 0;  // Failed assertion count

	assign any_wr = wr_7ffd_cand | wr_1ffd_cand | wr_eff7_cand;

	a_strobes: assert property (@(posedge clk_sys) !(ram_rd && ram_we))
		else begin
			error_count++;
			$error("ram_rd and ram_we high together");
		end

	a_stable: assert property (@(posedge clk_sys) disable iff (reset)
		!any_wr |=> ($stable(page_7ffd) && $stable(page_1ffd) && $stable(page_128k)))
		else begin
			error_count++;
			$error("paging register changed without a write pulse");
		end

	a_lock: assert property (@(posedge clk_sys) disable iff (reset)
		page_lock |=> $stable(page_7ffd))
		else begin
			error_count++;
			$error("7FFD register changed while locked");
		end

endmodule

bind zx_core_top tb_zx_core_sva tb_zx_core_sva_inst (
	.clk_sys      (clk_sys),
	.reset        (reset),
	.ram_rd       (ram_rd),
	.ram_we       (ram_we),
	.wr_7ffd_cand (wr_7ffd_cand),
	.wr_1ffd_cand (wr_1ffd_cand),
	.wr_eff7_cand (wr_eff7_cand),
	.page_7ffd    (page_7ffd),
	.page_1ffd    (page_1ffd),
	.page_128k    (page_128k),
	.page_lock    (paging_regs_inst.page_lock)
);

`default_nettype wire

// ==== zx_core_top.sv ====
//====================================================================
// Memory and I/O core top level
//   I/O write decode and ULA port, paging registers,
//   memory map and input port read mux
//====================================================================
`timescale 1ns/10ps
`default_nettype none

module zx_core_top
	import zx_pkg::*;
#(
	parameter int RAM_AW = ram_aw_default
)(
	input  wire               clk_sys,
	input  wire               reset,
	input  wire         [2:0] machine,
	// Bus master
	input  wire  [cpu_aw-1:0] addr,
	input  wire         [7:0] dout,
	input  wire               mreq,
	input  wire               iorq,
	input  wire               rd,
	input  wire               wr,
	input  wire               m1,
	output logic        [7:0] din,
	// External RAM and ROM
	output logic [RAM_AW-1:0] ram_addr,
	output logic              ram_rd,
	output logic              ram_we,
	output logic        [7:0] ram_wdata,
	input  wire         [7:0] ram_rdata,
	// ULA port
	output logic        [2:0] border_color,
	output logic              ear_out,
	output logic              mic_out,
	// Keyboard and joysticks
	input  wire        [39:0] key_matrix,
	input  wire         [5:0] joy0,
	input  wire         [5:0] joy1,
	input  wire         [2:0] jsel
);

	logic       wr_7ffd_cand;
	logic       wr_1ffd_cand;
	logic       wr_eff7_cand;
	page_7ffd_u page_7ffd;
	logic [7:0] page_1ffd;
	logic [2:0] page_128k;
	logic       zx48;
	logic       plus3;

	ula_io ula_io_inst (
		.clk_sys      (clk_sys),
		.reset        (reset),
		.addr         (addr),
		.dout         (dout),
		.iorq         (iorq),
		.wr           (wr),
		.m1           (m1),
		.wr_7ffd_cand (wr_7ffd_cand),
		.wr_1ffd_cand (wr_1ffd_cand),
		.wr_eff7_cand (wr_eff7_cand),
		.border_color (border_color),
		.ear_out      (ear_out),
		.mic_out      (mic_out)
	);

	paging_regs #(.RAM_AW(RAM_AW)) paging_regs_inst (
		.clk_sys      (clk_sys),
		.reset        (reset),
		.machine      (machine),
		.dout         (dout),
		.addr14       (addr[14]),
		.wr_7ffd_cand (wr_7ffd_cand),
		.wr_1ffd_cand (wr_1ffd_cand),
		.wr_eff7_cand (wr_eff7_cand),
		.page_7ffd    (page_7ffd),
		.page_1ffd    (page_1ffd),
		.page_128k    (page_128k),
		.zx48         (zx48),
		.plus3        (plus3),
		.page_lock    ()  // Watched inside paging_regs only
	);

	mem_map #(.RAM_AW(RAM_AW)) mem_map_inst (
		.addr      (addr),
		.mreq      (mreq),
		.rd        (rd),
		.wr        (wr),
		.dout      (dout),
		.page_7ffd (page_7ffd),
		.page_1ffd (page_1ffd),
		.page_128k (page_128k),
		.zx48      (zx48),
		.plus3     (plus3),
		.ram_addr  (ram_addr),
		.ram_rd    (ram_rd),
		.ram_we    (ram_we),
		.ram_wdata (ram_wdata)
	);

	input_ports input_ports_inst (
		.addr       (addr),
		.mreq       (mreq),
		.iorq       (iorq),
		.rd         (rd),
		.m1         (m1),
		.ram_rdata  (ram_rdata),
		.key_matrix (key_matrix),
		.joy0       (joy0),
		.joy1       (joy1),
		.jsel       (jsel),
		.din        (din)
	);

endmodule

`default_nettype wire

// ==== input_ports.sv ====
//====================================================================
// CPU read side
//   keyboard half-row scan on the even ports
//   Kempston, Sinclair I/II and cursor joystick mapping
//   read data multiplexer for memory and I/O reads
//====================================================================
`timescale 1ns/10ps
`default_nettype none

module input_ports
	import zx_pkg::*;
(
	input  wire [cpu_aw-1:0] addr,
	input  wire              mreq,
	input  wire              iorq,
	input  wire              rd,
	input  wire              m1,
	input  wire        [7:0] ram_rdata,
	input  wire       [39:0] key_matrix,
	input  wire        [5:0] joy0,
	input  wire        [5:0] joy1,
	input  wire        [2:0] jsel,
	output logic       [7:0] din
);

	// Joystick bits are right, left, down, up, fire1, fire2 from bit 0

	// Keys 6..0 on the 6-0 half row
	function automatic logic [4:0] map_sinclair1(input logic [5:0] j);
		return {j[1], j[0], j[2], j[3], j[4]};
	endfunction

	// Keys 1..5 on the 1-5 half row
	function automatic logic [4:0] map_sinclair2(input logic [5:0] j);
		return {j[4], j[3], j[2], j[0], j[1]};
	endfunction

	// Keys 6, 7, 8 and 0 of the 6-0 half row, 5 handled apart
	function automatic logic [4:0] map_cursor(input logic [5:0] j);
		return {j[2], j[3], j[0], 1'b0, j[4]};
	endfunction

	logic [4:0] key_data;
	logic [5:0] joyk;
	logic [4:0] joys1;
	logic [4:0] joys2;
	logic [4:0] joyc1;
	logic [4:0] joyc2;
	logic [4:0] joy_kbd;

	// Each low address bit A8..A15 selects one half row
	always_comb begin
		key_data = 5'b11111;
		for (int r = 0; r < 8; r++) begin
			if (!addr[8 + r]) begin
				key_data = key_data & ~key_matrix[r*5 +: 5];  // Pressed reads 0
			end
		end
	end

	assign joyk = joy0 | joy1;

	//================================================================
	// Joystick to key mapping
	//================================================================
	assign joys1 = ({5{jsel[0]}} & map_sinclair1(joy0))
		| ({5{jsel[1:0] == 2'd1}} & map_sinclair1(joy1));
	assign joys2 = ({5{jsel[1]}} & map_sinclair2(joy1))
		| ({5{jsel[1:0] == 2'd2}} & map_sinclair2(joy0));
	assign joyc1 = {5{jsel[2]}} & (map_cursor(joy0) | map_cursor(joy1));
	assign joyc2 = {5{jsel[2]}} & {joy0[1] | joy1[1], 4'b0000};  // Left is key 5

	// A12 picks the 6-0 row, A11 the 1-5 row
	assign joy_kbd = ({5{addr[12]}} | ~(joys1 | joyc1))
		& ({5{addr[11]}} | ~(joys2 | joyc2));

	// Read data priority
	always_comb begin
		if (mreq & rd) begin
			din = ram_rdata;
		end else if (m1 | ~iorq | ~rd) begin
			din = 8'hFF;  // Idle bus or interrupt acknowledge
		end else if (({2'b00, addr[5:0]} == port_kempston_lo) && (jsel == 3'd0)) begin
			din = {2'b00, joyk};
		end else if (!addr[0]) begin
			din = {3'b111, key_data & joy_kbd};
		end else begin
			din = 8'hFF;
		end
	end

endmodule

`default_nettype wire

// ==== mem_map.sv ====
//====================================================================
// Memory map
//   ROM page select for 48K, 128K and +3
//   normal and +3 special (all RAM) slot tables
//   external RAM address and read and write strobes
//====================================================================
`timescale 1ns/10ps
`default_nettype none

module mem_map
	import zx_pkg::*;
#(
	parameter int RAM_AW = ram_aw_default
)(
	input  wire  [cpu_aw-1:0] addr,
	input  wire               mreq,
	input  wire               rd,
	input  wire               wr,
	input  wire         [7:0] dout,
	input  page_7ffd_u        page_7ffd,
	input  wire         [7:0] page_1ffd,
	input  wire         [2:0] page_128k,
	input  wire               zx48,
	input  wire               plus3,
	output logic [RAM_AW-1:0] ram_addr,
	output logic              ram_rd,
	output logic              ram_we,
	output logic        [7:0] ram_wdata
);

	logic  [3:0] page_rom;
	logic        page_special;
	logic  [1:0] sp;          // 1FFD bits 2:1 pick the special layout
	logic [20:0] map_addr;    // Widest mapped address is a ROM page

	assign page_special = page_1ffd[0];
	assign sp           = page_1ffd[2:1];

	// +3 has four ROMs, the others two plus the 48K image
	assign page_rom = plus3 ? {2'b10, page_1ffd[2], page_7ffd.std.rom48}
		: {zx48, 2'b11, zx48 | page_7ffd.std.rom48};

	//================================================================
	// Slot tables
	//================================================================
	always_comb begin
		if (!page_special) begin
			case (addr[15:14])
				2'd0:    map_addr = {rom_region_hi, page_rom, addr[13:0]};
				2'd1:    map_addr = {4'd0, 3'd5, addr[13:0]};
				2'd2:    map_addr = {4'd0, 3'd2, addr[13:0]};
				default: map_addr = {1'b0, page_128k, page_7ffd.std.bank, addr[13:0]};
			endcase
		end else begin
			// Banks 0-3, 4-7, 4,5,6,3 and 4,7,6,3
			case (addr[15:14])
				2'd0:    map_addr = {4'd0, |sp, 2'b00, addr[13:0]};
				2'd1:    map_addr = {4'd0, |sp, &sp, 1'b1, addr[13:0]};
				2'd2:    map_addr = {4'd0, |sp, 2'b10, addr[13:0]};
				default: map_addr = {4'd0, ~sp[1] & sp[0], 2'b11, addr[13:0]};
			endcase
		end
	end

	// Upper bits zero
	assign ram_addr  = RAM_AW'(map_addr);

	assign ram_rd    = mreq & rd;
	// ROM slot is write protected unless it holds RAM
	assign ram_we    = mreq & wr & (page_special | addr[15] | addr[14]);
	assign ram_wdata = dout;

endmodule

`default_nettype wire

// ==== paging_regs.sv ====
//====================================================================
// Paging registers
//   7FFD, 1FFD (+3) and EFF7 (Pentagon 1024)
//   machine mode flags taken from the mode input during reset
//   page lock and Pentagon extended bank
//====================================================================
`timescale 1ns/10ps
`default_nettype none

module paging_regs
	import zx_pkg::*;
#(
	parameter int RAM_AW = ram_aw_default
)(
	input  wire        clk_sys,
	input  wire        reset,
	input  wire  [2:0] machine,
	input  wire  [7:0] dout,
	input  wire        addr14,
	input  wire        wr_7ffd_cand,
	input  wire        wr_1ffd_cand,
	input  wire        wr_eff7_cand,
	output page_7ffd_u page_7ffd,
	output logic [7:0] page_1ffd,
	output logic [2:0] page_128k,
	output logic       zx48,
	output logic       plus3,
	output logic       page_lock
);

	// Extended banks need 1 MB of RAM below the ROM area
	localparam logic [2:0] ext_mask = (RAM_AW >= 21) ? 3'b111 : 3'b000;

	page_7ffd_u wr_byte;   // Bus byte seen through the union
	logic [7:0] page_eff7;
	logic       p1024;
	logic       wr_7ffd;
	logic       wr_1ffd;
	logic       wr_eff7;

	assign wr_byte = dout;

	// In Pentagon mode bit 5 locks only with EFF7 bit 2 set
	assign page_lock = zx48
		| (~p1024 & page_7ffd.std.lock)
		| (p1024 & page_eff7[2] & page_7ffd.pent.ext_bank[0]);

	// +3 needs A14 high to tell 7FFD apart from 1FFD
	assign wr_7ffd = wr_7ffd_cand & (addr14 | ~plus3) & ~page_lock;
	assign wr_1ffd = wr_1ffd_cand & plus3 & ~page_lock;
	assign wr_eff7 = wr_eff7_cand & p1024;

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			page_7ffd <= '0;
			page_1ffd <= 8'd0;
			page_eff7 <= 8'd0;
			page_128k <= 3'd0;
			case (machine)
				mode_p1024: {p1024, zx48, plus3} <= 3'b100;
				mode_48:    {p1024, zx48, plus3} <= 3'b010;
				mode_plus3: {p1024, zx48, plus3} <= 3'b001;
				mode_128:   {p1024, zx48, plus3} <= 3'b000;
				default:    {p1024, zx48, plus3} <= 3'b000;  // Profi runs as 128K
			endcase
		end else begin
			if (wr_7ffd) begin
				page_7ffd <= wr_byte;
				// Bank bits ordered 5, 7, 6 as on the Pentagon board
				if (p1024 & ~page_eff7[2]) begin
					page_128k <= {wr_byte.pent.ext_bank[0], wr_byte.pent.ext_bank[2:1]}
						& ext_mask;
				end
			end else if (wr_1ffd) begin
				page_1ffd <= dout;
			end
			if (wr_eff7) begin
				page_eff7 <= dout;  // Bit 2 selects plain 128K paging
			end
		end
	end

endmodule

`default_nettype wire

// ==== ula_io.sv ====
//====================================================================
// I/O write side of the core
//   edge detect on the CPU I/O write strobe
//   candidate decode of the 7FFD, 1FFD and EFF7 paging ports
//   ULA output port at FE (border, EAR, MIC)
//====================================================================
`timescale 1ns/10ps
`default_nettype none

module ula_io
	import zx_pkg::*;
(
	input  wire              clk_sys,
	input  wire              reset,
	input  wire [cpu_aw-1:0] addr,
	input  wire        [7:0] dout,
	input  wire              iorq,
	input  wire              wr,
	input  wire              m1,
	output logic             wr_7ffd_cand,
	output logic             wr_1ffd_cand,
	output logic             wr_eff7_cand,
	output logic       [2:0] border_color,
	output logic             ear_out,
	output logic             mic_out
);

	logic io_wr;
	logic io_wr_q;     // Strobe one cycle back
	logic io_wr_pulse;
	logic sel_7ffd;
	logic sel_1ffd;
	logic sel_eff7;
	logic sel_fe;

	// Interrupt acknowledge also asserts iorq, so m1 excludes it
	assign io_wr = iorq & wr & ~m1;

	always_ff @(posedge clk_sys) begin
		io_wr_q <= io_wr;
	end

	// One pulse per bus cycle however long the strobe is held
	assign io_wr_pulse = io_wr & ~io_wr_q;

	//================================================================
	// Port decode, partial as on the real machines
	//================================================================
	assign sel_7ffd = ~addr[15] & ~addr[1];
	assign sel_1ffd = (addr[15:12] == 4'b0001) & ~addr[1];
	assign sel_eff7 = (addr[15:13] == 3'b111) & ~addr[12] & ~addr[3];
	assign sel_fe   = ~addr[0];  // Any even port

	// Mode qualifiers are applied in paging_regs
	assign wr_7ffd_cand = io_wr_pulse & sel_7ffd;
	assign wr_1ffd_cand = io_wr_pulse & sel_1ffd;
	assign wr_eff7_cand = io_wr_pulse & sel_eff7;

	// ULA output port
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			border_color <= 3'd0;
			ear_out      <= 1'b0;
			mic_out      <= 1'b0;
		end else if (io_wr_pulse & sel_fe) begin
			border_color <= dout[2:0];
			ear_out      <= dout[4];
			mic_out      <= dout[3];  // MIC sits below EAR
		end
	end

endmodule

`default_nettype wire

// ==== zx_pkg.sv ====
//====================================================================
// Shared definitions for the memory and I/O core
//   machine mode codes, bus and RAM widths
//   I/O port and ROM area constants
//   7FFD paging byte with its standard and Pentagon views
//====================================================================
`default_nettype none

package zx_pkg;

	// Bus widths
	localparam int cpu_aw         = 16;
	localparam int ram_aw_default = 25;  // 32 MB external space

	//================================================================
	// Machine modes
	//================================================================
	localparam logic [2:0] mode_128   = 3'd0;  // 128K/+2
	localparam logic [2:0] mode_p1024 = 3'd1;  // Pentagon 1024K
	localparam logic [2:0] mode_48    = 3'd3;
	localparam logic [2:0] mode_plus3 = 3'd4;  // +2A/+3

	// Kempston port, matched on address bits 5:0
	localparam logic [7:0] port_kempston_lo = 8'h1F;

	// ROM pages sit above the RAM banks
	localparam logic [2:0] rom_region_hi = 3'b101;

	//================================================================
	// 7FFD paging byte
	//================================================================
	typedef struct packed {
		logic [1:0] spare;
		logic       lock;      // Paging off until reset
		logic       rom48;
		logic       screen;    // Shadow screen in bank 7
		logic [2:0] bank;      // Bank at C000
	} page_std_t;

	// Pentagon 1024 reuses bits 7:5 as extra bank bits
	typedef struct packed {
		logic [2:0] ext_bank;  // Bit 5 doubles as the lock
		logic       rom48;
		logic       screen;
		logic [2:0] bank;
	} page_pent_t;

	typedef union packed {
		page_std_t  std;
		page_pent_t pent;
	} page_7ffd_u;

endpackage

`default_nettype wire
